// File: source/snes_pkg.sv
`default_nettype none

package snes_pkg;

  localparam int SNES_ADDR_W = 24;
  localparam int SNES_DATA_W = 8;
  localparam int SYNC_DEPTH  = 7; // shift history per strobe

  // history stages [SYNC_DEPTH-1:1], newest sample on the right
  localparam logic [SYNC_DEPTH-2:0] PAT_FALL = 6'b111110;
  localparam logic [SYNC_DEPTH-2:0] PAT_RISE = 6'b000001;

  typedef enum logic {
    lorom = 1'b0,
    hirom = 1'b1
  } mapper_e;

  // one console address word, seen through either mapper
  typedef union packed {
    struct packed {
      logic [7:0]  bank;
      logic        a15;    // set for the upper half of a bank
      logic [14:0] offset;
    } lo;
    struct packed {
      logic        spare;
      logic        rom_sel; // address bit 22
      logic [21:0] offset;
    } hi;
  } snes_addr_u;

endpackage

`default_nettype wire

// File: source/mem_pkg.sv
`default_nettype none

package mem_pkg;

  localparam int ROM_ADDR_W        = 24;
  localparam int ROM_DATA_W        = 16;
  localparam int ROM_CYCLE_LEN     = 6;   // addr state lasts this plus one
  localparam int SNES_DEAD_TIMEOUT = 200; // low cpu clock cycles

  localparam int DELAY_W    = $clog2(ROM_CYCLE_LEN + 1);
  localparam int DEAD_CNT_W = $clog2(SNES_DEAD_TIMEOUT + 2);

  // one-hot slot states
  typedef enum logic [4:0] {
    idle    = 5'b00001,
    rd_addr = 5'b00010,
    rd_end  = 5'b00100,
    wr_addr = 5'b01000,
    wr_end  = 5'b10000
  } slot_state_e;

endpackage

`default_nettype wire

// File: source/snes_bus_if.sv
`timescale 1ns/10ps
`default_nettype none

interface snes_bus_if;
  import snes_pkg::*;

  snes_addr_u addr;        // settled address
  logic       read;        // levels, active low
  logic       write;
  logic       rd_start;    // one-cycle edge strobes
  logic       rd_end;
  logic       cycle_start;
  logic       cycle_end;
  logic       dead;        // cpu clock stopped

  modport sampler (output addr, read, write, rd_start, rd_end, cycle_start, cycle_end, dead);
  modport consumer (input addr, read, write, rd_start, rd_end, cycle_start, cycle_end, dead);

endinterface

`default_nettype wire

// File: source/mem_slot_if.sv
`timescale 1ns/10ps
`default_nettype none

interface mem_slot_if;
  import mem_pkg::*;

  logic                  mcu_hit;   // mcu owns the ROM bus
  logic                  wr_hit;
  logic                  rd_sample; // capture read data
  logic [ROM_ADDR_W-1:0] slot_addr;

  modport arbiter (output mcu_hit, wr_hit, rd_sample, slot_addr);
  modport port (input mcu_hit, wr_hit, rd_sample, slot_addr);

endinterface

`default_nettype wire

// File: source/snes_bus_sampler.sv
`timescale 1ns/10ps
`default_nettype none

module snes_bus_sampler (
  input  wire logic                             clk2,
  input  wire logic                             rst,
  input  wire logic [snes_pkg::SNES_ADDR_W-1:0] snes_addr_in,
  input  wire logic                             snes_read_in,
  input  wire logic                             snes_write_in,
  input  wire logic                             snes_cpu_clk_in,
  snes_bus_if.sampler                           bus
);
  import snes_pkg::*;
  import mem_pkg::*;

  logic [SYNC_DEPTH-1:0]  read_hist;
  logic [SYNC_DEPTH-1:0]  write_hist;
  logic [SYNC_DEPTH-1:0]  cpu_clk_hist;
  logic [SNES_ADDR_W-1:0] addr_hist [SYNC_DEPTH];
  logic [DEAD_CNT_W-1:0]  dead_cnt;
  logic                   dead_r;

  ////////////////////////////////////////////////////////////////////////////
  // shift histories
  always_ff @(posedge clk2) begin
    if (rst) begin
      read_hist    <= '1; // bus idle
      write_hist   <= '1;
      cpu_clk_hist <= '0;
    end else begin
      read_hist    <= {read_hist[SYNC_DEPTH-2:0], snes_read_in};
      write_hist   <= {write_hist[SYNC_DEPTH-2:0], snes_write_in};
      cpu_clk_hist <= {cpu_clk_hist[SYNC_DEPTH-2:0], snes_cpu_clk_in};
    end
  end

  always_ff @(posedge clk2) begin
    addr_hist[0] <= snes_addr_in;
    for (int i = 1; i < SYNC_DEPTH; i++) begin
      addr_hist[i] <= addr_hist[i-1];
    end
  end

  // address gets the longest settle time
  assign bus.addr  = addr_hist[SYNC_DEPTH-1] & addr_hist[SYNC_DEPTH-2];
  assign bus.read  = read_hist[1] & read_hist[2];
  assign bus.write = write_hist[1] & write_hist[2];

  assign bus.rd_start    = (read_hist[SYNC_DEPTH-1:1] == PAT_FALL);
  assign bus.rd_end      = (read_hist[SYNC_DEPTH-1:1] == PAT_RISE);
  assign bus.cycle_start = (cpu_clk_hist[SYNC_DEPTH-1:1] == PAT_RISE);
  assign bus.cycle_end   = (cpu_clk_hist[SYNC_DEPTH-1:1] == PAT_FALL);

  ////////////////////////////////////////////////////////////////////////////
  // dead detector
  always_ff @(posedge clk2) begin
    if (rst) begin
      dead_cnt <= '0;
      dead_r   <= 1'b1;
    end else if (cpu_clk_hist[1]) begin
      dead_cnt <= '0;
      dead_r   <= 1'b0;
    end else begin
      if (dead_cnt <= DEAD_CNT_W'(SNES_DEAD_TIMEOUT)) begin
        dead_cnt <= dead_cnt + 1'b1; // stops just past the limit
      end
      if (dead_cnt > DEAD_CNT_W'(SNES_DEAD_TIMEOUT)) begin
        dead_r <= 1'b1;
      end
    end
  end

  assign bus.dead = dead_r;

endmodule

`default_nettype wire

// File: source/rom_mapper.sv
`timescale 1ns/10ps
`default_nettype none

module rom_mapper (
  snes_bus_if.consumer                         bus,
  input  wire snes_pkg::mapper_e               mapper,
  input  wire logic [mem_pkg::ROM_ADDR_W-1:0]  rom_mask,
  output logic                                 rom_hit,
  output logic [mem_pkg::ROM_ADDR_W-1:0]       mapped_addr
);
  import snes_pkg::*;
  import mem_pkg::*;

  logic [ROM_ADDR_W-1:0] lo_addr;
  logic [ROM_ADDR_W-1:0] hi_addr;

  // LoROM packs 32k halves back to back, HiROM is linear
  assign lo_addr = ROM_ADDR_W'({bus.addr.lo.bank[6:0], bus.addr.lo.offset});
  assign hi_addr = ROM_ADDR_W'(bus.addr.hi.offset);

  always_comb begin
    if (mapper == hirom) begin
      rom_hit     = bus.addr.hi.rom_sel;
      mapped_addr = hi_addr & rom_mask;
    end else begin
      rom_hit     = bus.addr.lo.a15;
      mapped_addr = lo_addr & rom_mask;
    end
  end

endmodule

`default_nettype wire

// File: source/slot_arbiter.sv
`timescale 1ns/10ps
`default_nettype none

module slot_arbiter (
  input  wire logic                            clk2,
  input  wire logic                            rst,
  snes_bus_if.consumer                         bus,
  input  wire logic                            rom_hit,
  input  wire logic                            mcu_rrq,
  input  wire logic                            mcu_wrq,
  input  wire logic [mem_pkg::ROM_ADDR_W-1:0]  mcu_addr,
  output logic                                 mcu_rdy,
  mem_slot_if.arbiter                          slot
);
  import mem_pkg::*;

  slot_state_e           state;
  logic [DELAY_W-1:0]    delay;
  logic [ROM_ADDR_W-1:0] req_addr;
  logic                  rd_pend;
  logic                  wr_pend;
  logic                  rdy_r;
  logic                  free_strobe;
  logic                  free_slot;

  ////////////////////////////////////////////////////////////////////////////
  // request latch
  always_ff @(posedge clk2) begin
    if (rst) begin
      rd_pend <= 1'b0;
      wr_pend <= 1'b0;
      rdy_r   <= 1'b1;
    end else if (mcu_rrq) begin
      rd_pend <= 1'b1;
      rdy_r   <= 1'b0;
    end else if (mcu_wrq) begin
      wr_pend <= 1'b1;
      rdy_r   <= 1'b0;
    end else if (state == rd_end || state == wr_end) begin
      rd_pend <= 1'b0;
      wr_pend <= 1'b0;
      rdy_r   <= 1'b1;
    end
  end

  always_ff @(posedge clk2) begin
    if (mcu_rrq | mcu_wrq) req_addr <= mcu_addr;
  end

  // console cycle that leaves the ROM alone
  always_ff @(posedge clk2) begin
    if (rst) free_strobe <= 1'b0;
    else     free_strobe <= bus.cycle_start & ~rom_hit;
  end

  assign free_slot = bus.cycle_end | free_strobe | bus.dead;

  ////////////////////////////////////////////////////////////////////////////
  // slot FSM
  always_ff @(posedge clk2) begin
    if (rst) begin
      state <= idle;
    end else if (bus.dead & bus.cycle_start) begin
      state <= idle; // console woke up, retry later
    end else begin
      case (state)
        idle: begin
          if (free_slot & rd_pend)      state <= rd_addr;
          else if (free_slot & wr_pend) state <= wr_addr;
        end
        rd_addr: if (delay == '0) state <= rd_end;
        wr_addr: if (delay == '0) state <= wr_end;
        default: state <= idle;
      endcase
    end
  end

  always_ff @(posedge clk2) begin
    if (state == idle) delay <= DELAY_W'(ROM_CYCLE_LEN);
    else               delay <= delay - 1'b1;
  end

  assign mcu_rdy        = rdy_r;
  assign slot.mcu_hit   = (state == rd_addr) | (state == wr_addr);
  assign slot.wr_hit    = (state == wr_addr);
  assign slot.rd_sample = (state == rd_addr);
  assign slot.slot_addr = req_addr;

endmodule

`default_nettype wire

// File: source/rom_port.sv
`timescale 1ns/10ps
`default_nettype none

module rom_port (
  input  wire logic                             clk2,
  input  wire logic                             rst,
  snes_bus_if.consumer                          bus,
  mem_slot_if.port                              slot,
  input  wire logic                             rom_hit,
  input  wire logic [mem_pkg::ROM_ADDR_W-1:0]   mapped_addr,
  input  wire logic [snes_pkg::SNES_DATA_W-1:0] mcu_dout,
  input  wire logic [mem_pkg::ROM_DATA_W-1:0]   rom_data_in,
  output logic [mem_pkg::ROM_ADDR_W-2:0]        rom_addr,
  output logic                                  rom_we,
  output logic                                  rom_bhe,
  output logic                                  rom_ble,
  output logic [mem_pkg::ROM_DATA_W-1:0]        rom_data_out,
  output logic [snes_pkg::SNES_DATA_W-1:0]      snes_data_out,
  output logic                                  snes_data_oe,
  output logic [snes_pkg::SNES_DATA_W-1:0]      mcu_din
);
  import snes_pkg::*;
  import mem_pkg::*;

  logic [ROM_ADDR_W-1:0]  sel_addr;
  logic                   odd;
  logic [SNES_DATA_W-1:0] lane_byte;

  assign sel_addr = slot.mcu_hit ? slot.slot_addr : mapped_addr;
  assign rom_addr = sel_addr[ROM_ADDR_W-1:1]; // word address
  assign odd      = sel_addr[0];

  assign rom_bhe = odd; // even byte sits on the high lane
  assign rom_ble = ~odd;
  assign rom_we  = ~slot.wr_hit;

  assign rom_data_out = {mcu_dout, mcu_dout}; // lane strobes pick one
  assign lane_byte    = odd ? rom_data_in[7:0] : rom_data_in[15:8];

  assign snes_data_out = lane_byte;
  assign snes_data_oe  = rom_hit & ~bus.read & ~slot.mcu_hit;

  always_ff @(posedge clk2) begin
    if (rst)                 mcu_din <= '0;
    else if (slot.rd_sample) mcu_din <= lane_byte; // last sample wins
  end

endmodule

`default_nettype wire

// File: source/cart_top.sv
`timescale 1ns/10ps
`default_nettype none

module cart_top (
  input  wire logic                             clk2,
  input  wire logic                             rst,
  input  wire logic [snes_pkg::SNES_ADDR_W-1:0] snes_addr_in,
  input  wire logic                             snes_read_in,
  input  wire logic                             snes_write_in,
  input  wire logic                             snes_cpu_clk_in,
  input  wire snes_pkg::mapper_e                mapper,
  input  wire logic [mem_pkg::ROM_ADDR_W-1:0]   rom_mask,
  input  wire logic                             mcu_rrq,
  input  wire logic                             mcu_wrq,
  input  wire logic [mem_pkg::ROM_ADDR_W-1:0]   mcu_addr,
  input  wire logic [snes_pkg::SNES_DATA_W-1:0] mcu_dout,
  output logic                                  mcu_rdy,
  output logic [snes_pkg::SNES_DATA_W-1:0]      mcu_din,
  input  wire logic [mem_pkg::ROM_DATA_W-1:0]   rom_data_in,
  output logic [mem_pkg::ROM_ADDR_W-2:0]        rom_addr,
  output logic                                  rom_we,
  output logic                                  rom_bhe,
  output logic                                  rom_ble,
  output logic [mem_pkg::ROM_DATA_W-1:0]        rom_data_out,
  output logic [snes_pkg::SNES_DATA_W-1:0]      snes_data_out,
  output logic                                  snes_data_oe
);
  import mem_pkg::*;

  logic                  rom_hit;
  logic [ROM_ADDR_W-1:0] mapped_addr;

  snes_bus_if bus_if ();
  mem_slot_if slot_if ();

  ////////////////////////////////////////////////////////////////////////////
  // console side in, mapper, arbiter, ROM side out
  snes_bus_sampler u_sampler (
    .clk2            (clk2),
    .rst             (rst),
    .snes_addr_in    (snes_addr_in),
    .snes_read_in    (snes_read_in),
    .snes_write_in   (snes_write_in),
    .snes_cpu_clk_in (snes_cpu_clk_in),
    .bus             (bus_if)
  );

  rom_mapper u_mapper (
    .bus         (bus_if),
    .mapper      (mapper),
    .rom_mask    (rom_mask),
    .rom_hit     (rom_hit),
    .mapped_addr (mapped_addr)
  );

  slot_arbiter u_arbiter (
    .clk2     (clk2),
    .rst      (rst),
    .bus      (bus_if),
    .rom_hit  (rom_hit),
    .mcu_rrq  (mcu_rrq),
    .mcu_wrq  (mcu_wrq),
    .mcu_addr (mcu_addr),
    .mcu_rdy  (mcu_rdy),
    .slot     (slot_if)
  );

  rom_port u_rom_port (
    .clk2          (clk2),
    .rst           (rst),
    .bus           (bus_if),
    .slot          (slot_if),
    .rom_hit       (rom_hit),
    .mapped_addr   (mapped_addr),
    .mcu_dout      (mcu_dout),
    .rom_data_in   (rom_data_in),
    .rom_addr      (rom_addr),
    .rom_we        (rom_we),
    .rom_bhe       (rom_bhe),
    .rom_ble       (rom_ble),
    .rom_data_out  (rom_data_out),
    .snes_data_out (snes_data_out),
    .snes_data_oe  (snes_data_oe),
    .mcu_din       (mcu_din)
  );

endmodule

`default_nettype wire

// File: verification/cart_sva.sv
`timescale 1ns/10ps
`default_nettype none

module cart_sva (
  input wire logic clk2,
  input wire logic rst,
  input wire logic mcu_rrq,
  input wire logic mcu_wrq,
  input wire logic mcu_rdy,
  input wire logic rom_we,
  input wire logic rom_bhe,
  input wire logic rom_ble
);

  // accepted request takes ready down
  rdy_drop: assert property (@(posedge clk2) disable iff (rst)
    (mcu_rrq | mcu_wrq) && mcu_rdy |=> !mcu_rdy)
    else $error("mcu ready still high the cycle after a request");

  lane_pair: assert property (@(posedge clk2) disable iff (rst) rom_bhe == !rom_ble)
    else $error("byte lane strobes not complementary");

  // ROM writes only inside an mcu access
  we_in_access: assert property (@(posedge clk2) disable iff (rst) !rom_we |-> !mcu_rdy)
    else $error("rom write enable low while mcu ready is high");

endmodule

bind cart_top cart_sva u_cart_sva (
  .clk2    (clk2),
  .rst     (rst),
  .mcu_rrq (mcu_rrq),
  .mcu_wrq (mcu_wrq),
  .mcu_rdy (mcu_rdy),
  .rom_we  (rom_we),
  .rom_bhe (rom_bhe),
  .rom_ble (rom_ble)
);

`default_nettype wire

// File: verification/cart_tb.sv
`timescale 1ns/10ps
`default_nettype none

module cart_tb;
  import snes_pkg::*;
  import mem_pkg::*;

  localparam int NUM_TESTS = 5;
  localparam int NUM_TRANS = 40;
  localparam int RUN_LIMIT = NUM_TESTS * NUM_TRANS * 100; // about 100 cycles per transaction

  logic                   clk2 = 1'b0;
  logic                   rst;
  logic [SNES_ADDR_W-1:0] snes_addr_in;
  logic                   snes_read_in;
  logic                   snes_write_in;
  wire                    snes_cpu_clk_in;
  mapper_e                mapper;
  logic [ROM_ADDR_W-1:0]  rom_mask;
  logic                   mcu_rrq;
  logic                   mcu_wrq;
  logic [ROM_ADDR_W-1:0]  mcu_addr;
  logic [SNES_DATA_W-1:0] mcu_dout;
  logic                   mcu_rdy;
  logic [SNES_DATA_W-1:0] mcu_din;
  logic [ROM_DATA_W-1:0]  rom_data_in;
  logic [ROM_ADDR_W-2:0]  rom_addr;
  logic                   rom_we;
  logic                   rom_bhe;
  logic                   rom_ble;
  logic [ROM_DATA_W-1:0]  rom_data_out;
  logic [SNES_DATA_W-1:0] snes_data_out;
  logic                   snes_data_oe;

  logic [1:0]  clk_mode;   // 0 high, 1 low, 2 random toggle
  logic        toggle_clk;
  int          cycles = 0;
  int          checks = 0;
  int          errors = 0;
  logic [15:0] rom_store [logic [ROM_ADDR_W-2:0]]; // words written through the ROM bus
  logic [7:0]  ref_bytes [logic [ROM_ADDR_W-1:0]]; // bytes the mcu wrote

  always #2 clk2 = ~clk2;

  assign snes_cpu_clk_in = (clk_mode == 2'd2) ? toggle_clk : (clk_mode == 2'd0);

  cart_top u_cart_top (.*);

  ////////////////////////////////////////////////////////////////////////////
  // ROM model
  function automatic logic [15:0] fill_word(input logic [22:0] w);
    return w[15:0] ^ {w[22:15], w[22:15]} ^ 16'ha5c3;
  endfunction

  function automatic logic [15:0] rom_word(input logic [22:0] w);
    if (rom_store.exists(w)) return rom_store[w];
    return fill_word(w);
  endfunction

  always_comb rom_data_in = rom_word(rom_addr);

  always @(posedge clk2) begin
    logic [15:0] word;
    if (!rom_we) begin
      word = rom_word(rom_addr);
      if (!rom_bhe) word[15:8] = rom_data_out[15:8]; // strobes active low
      if (!rom_ble) word[7:0] = rom_data_out[7:0];
      rom_store[rom_addr] = word;
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // reference model
  function automatic logic ref_hit(input mapper_e m, input logic [23:0] a);
    return (m == hirom) ? a[22] : a[15];
  endfunction

  function automatic logic [23:0] ref_map(input mapper_e m, input logic [23:0] a,
                                          input logic [23:0] mask);
    if (m == hirom) return {2'b00, a[21:0]} & mask;
    return {2'b00, a[22:16], a[14:0]} & mask; // drop a15 and pack the halves
  endfunction

  // even byte lives in the high half of the word
  function automatic logic [7:0] ref_byte(input logic [23:0] a);
    logic [15:0] w;
    if (ref_bytes.exists(a)) return ref_bytes[a];
    w = fill_word(a[23:1]);
    return a[0] ? w[7:0] : w[15:8];
  endfunction

  task automatic check_eq(input logic [31:0] actual, input logic [31:0] expected,
                          input string what);
    checks++;
    if (actual !== expected) begin
      errors++;
      $display("[FAIL] %0t: %s, got %0h, expected %0h", $time, what, actual, expected);
    end
  endtask

  task automatic step();
    @(posedge clk2);
    #1;
  endtask

  task automatic console_read(input mapper_e m, input logic [23:0] a, input logic [23:0] mask);
    mapper       = m;
    rom_mask     = mask;
    snes_addr_in = a;
    snes_read_in = 1'b0;
    repeat (12) step();
    check_eq(32'(snes_data_oe), 32'(ref_hit(m, a)), "console output enable");
    if (ref_hit(m, a)) begin
      check_eq(32'(snes_data_out), 32'(ref_byte(ref_map(m, a, mask))), "console read data");
    end
    snes_read_in = 1'b1;
    repeat (3) step();
  endtask

  task automatic mcu_access(input logic wr, input logic [23:0] a, input logic [7:0] d);
    while (!mcu_rdy) step();
    mcu_addr = a;
    mcu_dout = d; // held until ready returns
    mcu_wrq  = wr;
    mcu_rrq  = ~wr;
    step();
    mcu_wrq = 1'b0;
    mcu_rrq = 1'b0;
    check_eq(32'(mcu_rdy), 32'd0, "ready after request");
    while (!mcu_rdy) step();
    if (wr) ref_bytes[a] = d;
    else check_eq(32'(mcu_din), 32'(ref_byte(a)), "mcu read data");
  endtask

  task automatic report_test(input int num, input string name, input int first_err);
    $display("test %0d %s: %0d errors", num, name, errors - first_err);
  endtask

  // console cpu clock with each level held long enough to form an edge
  initial begin
    int hold;
    toggle_clk = 1'b1;
    forever begin
      @(negedge clk2);
      hold = 6 + $urandom_range(7);
      repeat (hold) step();
      toggle_clk = ~toggle_clk;
    end
  end

  always @(posedge clk2) begin
    cycles = cycles + 1;
    if (cycles >= RUN_LIMIT) begin
      $display("timeout: run did not finish within %0d cycles", RUN_LIMIT);
      $display("Test failed");
      $finish;
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // test sequence
  initial begin
    logic [23:0] a;
    logic [23:0] base;
    logic [7:0]  d;
    int          prev;
    void'($urandom(32'hd97e71bb));
    rst           = 1'b1;
    snes_addr_in  = '0;
    snes_read_in  = 1'b1;
    snes_write_in = 1'b1;
    mapper        = lorom;
    rom_mask      = '1;
    mcu_rrq       = 1'b0;
    mcu_wrq       = 1'b0;
    mcu_addr      = '0;
    mcu_dout      = '0;
    clk_mode      = 2'd0; // console alive
    repeat (5) step();
    rst = 1'b0;

    prev = errors;
    for (int i = 0; i < NUM_TRANS; i++) console_read(lorom, 24'($urandom), '1);
    report_test(1, "lorom reads", prev);

    prev = errors;
    for (int i = 0; i < NUM_TRANS; i++) console_read(hirom, 24'($urandom), 24'($urandom));
    report_test(2, "hirom masked reads", prev);

    prev = errors;
    for (int i = 0; i < NUM_TRANS; i++) begin
      a = 24'($urandom);
      if (i % 2 == 1) begin
        a[22] = 1'b0;
        console_read(hirom, a, '1);
      end else begin
        a[15] = 1'b0;
        console_read(lorom, a, '1);
      end
    end
    report_test(3, "rom misses", prev);

    // stop the cpu clock until the console counts as dead
    prev     = errors;
    clk_mode = 2'd1;
    repeat (SNES_DEAD_TIMEOUT + 10) step();
    for (int i = 0; i < NUM_TRANS; i++) begin
      a = 24'($urandom);
      d = 8'($urandom);
      mcu_access(1'b1, a, d);
      mcu_access(1'b0, a, 8'h00);
      mcu_access(1'b0, a ^ 24'd1, 8'h00); // other lane untouched
    end
    report_test(4, "mcu access while dead", prev);

    prev     = errors;
    clk_mode = 2'd2;
    base     = 24'($urandom);
    for (int i = 0; i < NUM_TRANS; i++) begin
      a = base + 24'($urandom_range(15));
      mcu_access(1'($urandom_range(1)), a, 8'($urandom));
    end
    report_test(5, "mcu access with live console", prev);

    $display("checks: %0d, errors: %0d", checks, errors);
    if (errors == 0) $display("Test completed successfully");
    else $display("Test failed");
    $finish;
  end

endmodule

`default_nettype wire

// File: flist.f
source/snes_pkg.sv
source/mem_pkg.sv
source/snes_bus_if.sv
source/mem_slot_if.sv
source/snes_bus_sampler.sv
source/rom_mapper.sv
source/slot_arbiter.sv
source/rom_port.sv
source/cart_top.sv
verification/cart_sva.sv
verification/cart_tb.sv

// File: Makefile
# Verilator build and run for the cartridge ROM bus controller

VERILATOR ?= verilator
TOP       ?= cart_tb
FLIST     ?= flist.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -j 0

SIM_BIN := $(BUILD_DIR)/V$(TOP)

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator, run, and search $(LOG) for a failure"
	@echo "  clean  remove $(BUILD_DIR) and $(LOG)"
	@echo "variables: VERILATOR TOP FLIST BUILD_DIR LOG VFLAGS"

$(SIM_BIN): $(FLIST) $(shell cat $(FLIST))
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(BUILD_DIR) -f $(FLIST)

test: $(SIM_BIN)
	-./$(SIM_BIN) > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -q "Test failed" $(LOG); then echo "simulation reported failure"; exit 1; fi
	@if ! grep -q "Test completed successfully" $(LOG); then echo "simulation did not finish"; exit 1; fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)
